// File: common/cpuPkg.sv
// Datapath types for the execute slice; all widths are set by the macros in cpu_defines.svh.
`include "cpu_defines.svh"

package cpuPkg;

    // One architectural data word, also the width of HI and LO.
    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] regAddr_t; // Index into the 32-entry register file.

    // Constant shift amount from the shamt field.
    typedef logic [`SHAMT_W-1:0] shamt_t;

    typedef logic [`OPCODE_W-1:0] opcode_t; // Primary opcode, bits 31:26.

    // Function field, also used as the internal ALU and multiply operation code.
    typedef logic [`FUNCT_W-1:0] funct_t;

    typedef logic [`IMM_W-1:0] immed_t; // I-type immediate, bits 15:0.

endpackage

// File: common/cpu_defines.svh
// MIPS32 opcode and function encodings; ALU_CLO and ALU_CLZ are internal codes, not ISA values.
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define SHAMT_W     5
`define OPCODE_W    6
`define FUNCT_W     6
`define IMM_W       16

// Primary opcodes.
`define ALU    6'h00
`define MULL   6'h1C
`define J      6'h02
`define JAL    6'h03
`define BEQ    6'h04
`define BNE    6'h05
`define BLEZ   6'h06
`define BGTZ   6'h07
`define ADDI   6'h08
`define ADDIU  6'h09
`define SLTI   6'h0A
`define SLTIU  6'h0B
`define ANDI   6'h0C
`define ORI    6'h0D
`define XORI   6'h0E
`define LUI    6'h0F
`define LB     6'h20
`define LH     6'h21
`define LWL    6'h22
`define LW     6'h23
`define LBU    6'h24
`define LHU    6'h25
`define LWR    6'h26
`define SB     6'h28
`define SH     6'h29
`define SWL    6'h2A
`define SW     6'h2B
`define SWR    6'h2E
`define LL     6'h30
`define SC     6'h38

// Function codes of the special group.
`define SLL    6'h00
`define SRL    6'h02
`define SRA    6'h03
`define SLLV   6'h04
`define SRLV   6'h06
`define SRAV   6'h07
`define JR     6'h08
`define JALR   6'h09
`define MOVZ   6'h0A
`define MOVN   6'h0B
`define MFHI   6'h10
`define MTHI   6'h11
`define MFLO   6'h12
`define MTLO   6'h13
`define MULT   6'h18
`define MULTU  6'h19
`define ADD    6'h20
`define ADDU   6'h21
`define SUB    6'h22
`define SUBU   6'h23
`define AND    6'h24
`define OR     6'h25
`define XOR    6'h26
`define NOR    6'h27
`define SLT    6'h2A
`define SLTU   6'h2B

// Function codes of the special2 group.
`define MADD   6'h00
`define MADDU  6'h01
`define MUL    6'h02
`define MSUB   6'h04
`define MSUBU  6'h05
`define CLZ    6'h20
`define CLO    6'h21

// CLZ and CLO clash with ADD and ADDU, so the decoder remaps them.
`define ALU_CLO 6'h3E
`define ALU_CLZ 6'h3F

`endif

// File: design/alu.sv
// Combinational integer ALU; no overflow traps, and ADDIU and SLTIU sign-extend as in MIPS32.
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
    input  cpuPkg::word_t  rsData,
    input  cpuPkg::word_t  rtData,
    input  cpuPkg::immed_t imm,
    input  cpuPkg::shamt_t shamt,
    input  cpuPkg::funct_t Func,
    input  logic           ALUSrc,
    input  logic           ShiftSel,
    input  logic           Unsgnsel,
    output cpuPkg::word_t  aluResult,
    output logic           condWrite
);

    cpuPkg::word_t  immExt;
    cpuPkg::word_t  opA;
    cpuPkg::word_t  opB;
    cpuPkg::shamt_t varAmt;
    logic           zeroExt;

    // Only the logical immediates take a zero-extended operand.
    assign zeroExt = Unsgnsel && ((Func == `AND) || (Func == `OR) || (Func == `XOR));

    always_comb
    begin
        if (ShiftSel)
            immExt = {imm, {`IMM_W{1'b0}}};      // LUI places the immediate in the upper half.
        else if (zeroExt)
            immExt = {{`IMM_W{1'b0}}, imm};
        else
            immExt = {{`IMM_W{imm[`IMM_W-1]}}, imm};
    end

    assign opA    = ShiftSel ? '0 : rsData;    // LUI ignores rs.
    assign opB    = ALUSrc ? immExt : rtData;
    assign varAmt = rsData[`SHAMT_W-1:0];

    always_comb
    begin
        condWrite = 1'b1;
        case (Func)
            `ADD, `ADDU: aluResult = opA + opB;
            `SUB, `SUBU: aluResult = opA - opB;
            `AND:        aluResult = opA & opB;
            `OR:         aluResult = opA | opB;
            `XOR:        aluResult = opA ^ opB;
            `NOR:        aluResult = ~(opA | opB);
            `SLL:        aluResult = opB << shamt;
            `SLLV:       aluResult = opB << varAmt;
            `SRL:        aluResult = opB >> shamt;
            `SRLV:       aluResult = opB >> varAmt;
            `SRA:        aluResult = $signed(opB) >>> shamt;
            `SRAV:       aluResult = $signed(opB) >>> varAmt;
            `SLT:        aluResult = {{(`WORD_W-1){1'b0}}, $signed(opA) < $signed(opB)};
            `SLTU:       aluResult = {{(`WORD_W-1){1'b0}}, opA < opB};
            `MOVN:
            begin
                aluResult = rsData;
                condWrite = (rtData != '0);
            end
            `MOVZ:
            begin
                aluResult = rsData;
                condWrite = (rtData == '0);
            end
            default:     aluResult = '0;
        endcase
    end

endmodule

// File: design/decoder.sv
// Combinational control table; branch, jump, memory and unknown opcodes leave every output low.
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decoder (
    input  cpuPkg::opcode_t OpCode,
    input  cpuPkg::funct_t  FuncCode,
    output logic            RegDst,
    output logic            ALUOp,
    output logic            MULOp,
    output logic            ALUSrc,
    output logic            RegWrite,
    output logic            ShiftSel,
    output logic            Unsgnsel,
    output cpuPkg::funct_t  Func
);

    always_comb
    begin
        RegDst   = 1'b0;
        ALUOp    = 1'b0;
        MULOp    = 1'b0;
        ALUSrc   = 1'b0;
        RegWrite = 1'b0;
        ShiftSel = 1'b0;
        Unsgnsel = 1'b0;
        Func     = '0;

        case (OpCode)
            `ALU:
                case (FuncCode)
                    `ADD, `ADDU, `SUB, `SUBU, `SLL, `SLLV, `SRA, `SRAV, `SRL, `SRLV,
                    `AND, `OR, `XOR, `NOR, `MOVN, `MOVZ, `SLT, `SLTU:
                    begin
                        RegDst   = 1'b1;
                        ALUOp    = 1'b1;
                        RegWrite = 1'b1;
                        Func     = FuncCode;
                    end

                    // These only change HI or LO.
                    `MULT, `MULTU, `MTHI, `MTLO:
                    begin
                        MULOp = 1'b1;
                        Func  = FuncCode;
                    end

                    `MFHI, `MFLO:
                    begin
                        RegDst   = 1'b1;
                        MULOp    = 1'b1;
                        RegWrite = 1'b1;
                        Func     = FuncCode;
                    end

                    `JR, `JALR:;
                    default:;
                endcase

            `MULL:
                case (FuncCode)
                    `CLO, `CLZ:
                    begin
                        RegDst   = 1'b1;
                        MULOp    = 1'b1;
                        RegWrite = 1'b1;
                        Func     = (FuncCode == `CLO) ? `ALU_CLO : `ALU_CLZ;
                    end

                    `MUL:
                    begin
                        RegDst   = 1'b1;
                        MULOp    = 1'b1;
                        RegWrite = 1'b1;
                        Func     = FuncCode;
                    end

                    `MADD, `MADDU, `MSUB, `MSUBU:
                    begin
                        MULOp = 1'b1;
                        Func  = FuncCode;
                    end

                    default:;
                endcase

            `ADDI, `ADDIU, `LUI, `ANDI, `ORI, `XORI, `SLTI, `SLTIU:
            begin
                ALUOp    = 1'b1;
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
                ShiftSel = (OpCode == `LUI);
                // Marks the unsigned forms; only the logical ones zero-extend.
                Unsgnsel = (OpCode == `ADDIU) || (OpCode == `ANDI) || (OpCode == `ORI) ||
                           (OpCode == `XORI) || (OpCode == `SLTIU);
                case (OpCode)
                    `ADDIU:  Func = `ADDU;
                    `ANDI:   Func = `AND;
                    `ORI:    Func = `OR;
                    `XORI:   Func = `XOR;
                    `SLTI:   Func = `SLT;
                    `SLTIU:  Func = `SLTU;
                    default: Func = `ADD;  // ADDI and LUI.
                endcase
            end

            `BEQ, `BNE, `BLEZ, `BGTZ, `J, `JAL:;
            `LB, `LBU, `LH, `LHU, `LW, `LWL, `LWR, `LL:;
            `SB, `SH, `SW, `SWL, `SWR, `SC:;
            default:;
        endcase
    end

endmodule

// File: design/executeCore.sv
// Decode and execute slice; operands arrive already read, with no back-pressure and one register stage.
`timescale 1ns/1ps

module executeCore (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  cpuPkg::word_t      instr,
    input  cpuPkg::word_t      rsData,
    input  cpuPkg::word_t      rtData,
    output logic               resultValid,
    output logic               writeEn,
    output cpuPkg::regAddr_t   writeReg,
    output cpuPkg::word_t      writeData
);

    cpuPkg::opcode_t  opCode;
    cpuPkg::regAddr_t rt;
    cpuPkg::regAddr_t rd;
    cpuPkg::shamt_t   shamt;
    cpuPkg::funct_t   funcCode;
    cpuPkg::immed_t   imm;

    logic             regDst;
    logic             aluOp;
    logic             mulOp;
    logic             aluSrc;
    logic             regWrite;
    logic             shiftSel;
    logic             unsgnSel;
    cpuPkg::funct_t   func;

    cpuPkg::word_t    aluResult;
    cpuPkg::word_t    mulResult;
    cpuPkg::word_t    result;
    logic             condWrite;

    assign opCode   = instr[31:26];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign shamt    = instr[10:6];
    assign funcCode = instr[5:0];
    assign imm      = instr[15:0];

    decoder decoderInst (
        .OpCode   (opCode),
        .FuncCode (funcCode),
        .RegDst   (regDst),
        .ALUOp    (aluOp),
        .MULOp    (mulOp),
        .ALUSrc   (aluSrc),
        .RegWrite (regWrite),
        .ShiftSel (shiftSel),
        .Unsgnsel (unsgnSel),
        .Func     (func)
    );

    alu aluInst (
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (imm),
        .shamt     (shamt),
        .Func      (func),
        .ALUSrc    (aluSrc),
        .ShiftSel  (shiftSel),
        .Unsgnsel  (unsgnSel),
        .aluResult (aluResult),
        .condWrite (condWrite)
    );

    mulUnit mulUnitInst (
        .clk       (clk),
        .arstN     (arstN),
        .mulStrobe (instrValid & mulOp),
        .Func      (func),
        .rsData    (rsData),
        .rtData    (rtData),
        .mulResult (mulResult)
    );

    // Instructions that use neither unit return zero.
    assign result = mulOp ? mulResult : (aluOp ? aluResult : '0);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            resultValid <= 1'b0;
            writeEn     <= 1'b0;
            writeReg    <= '0;
            writeData   <= '0;
        end
        else
        begin
            resultValid <= instrValid;
            writeEn     <= instrValid & regWrite & condWrite;
            if (instrValid)
            begin
                writeReg  <= regDst ? rd : rt;
                writeData <= result;
            end
        end
    end

endmodule

// File: mulUnit/mulUnit.sv
// HI/LO and multiply unit; a single-cycle multiplier, and HI/LO change only while mulStrobe is high.
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mulUnit (
    input  logic           clk,
    input  logic           arstN,
    input  logic           mulStrobe,
    input  cpuPkg::funct_t Func,
    input  cpuPkg::word_t  rsData,
    input  cpuPkg::word_t  rtData,
    output cpuPkg::word_t  mulResult
);

    cpuPkg::word_t     hi;
    cpuPkg::word_t     lo;
    cpuPkg::word_t     scanWord;
    logic [2*`WORD_W-1:0] sProd;
    logic [2*`WORD_W-1:0] uProd;
    logic [2*`WORD_W-1:0] product;
    logic              signedMul;
    logic [5:0]        leadCount;

    assign signedMul = (Func == `MULT) || (Func == `MADD) || (Func == `MSUB) || (Func == `MUL);

    // Operands are widened first so that the low 64 bits of each product are exact.
    assign sProd   = $signed({{`WORD_W{rsData[`WORD_W-1]}}, rsData}) *
                     $signed({{`WORD_W{rtData[`WORD_W-1]}}, rtData});
    assign uProd   = {{`WORD_W{1'b0}}, rsData} * {{`WORD_W{1'b0}}, rtData};
    assign product = signedMul ? sProd : uProd;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (mulStrobe)
        begin
            case (Func)
                `MULT, `MULTU: {hi, lo} <= product;
                `MADD, `MADDU: {hi, lo} <= {hi, lo} + product;
                `MSUB, `MSUBU: {hi, lo} <= {hi, lo} - product;
                `MTHI:         hi <= rsData;
                `MTLO:         lo <= rsData;
                default:;
            endcase
        end
    end

    // Counting leading ones is counting leading zeros of the inverted word.
    assign scanWord = (Func == `ALU_CLO) ? ~rsData : rsData;

    always_comb
    begin
        leadCount = 6'd32;
        for (int i = 0; i < `WORD_W; i++)
        begin
            if (scanWord[i])
                leadCount = 6'(31 - i); // The highest set bit wins.
        end
    end

    always_comb
    begin
        case (Func)
            `MFHI:              mulResult = hi;
            `MFLO:              mulResult = lo;
            `MUL:               mulResult = product[`WORD_W-1:0];
            `ALU_CLO, `ALU_CLZ: mulResult = {{(`WORD_W-6){1'b0}}, leadCount};
            default:            mulResult = '0;
        endcase
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the executeCore testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module executeCoreTb -f src.f -o executeCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/executeCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi
exit 0

// File: src.f
+incdir+common
common/cpuPkg.sv
design/decoder.sv
design/alu.sv
mulUnit/mulUnit.sv
design/executeCore.sv
testbench/executeCoreTb.sv

// File: testbench/executeCoreTb.sv
// Needs assertions enabled in the simulator; writeReg and writeData are compared only on cycles that write.
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeCoreTb;

    logic             clk = 1'b0;
    logic             arstN;
    logic             instrValid;
    cpuPkg::word_t    instr;
    cpuPkg::word_t    rsData;
    cpuPkg::word_t    rtData;
    logic             resultValid;
    logic             writeEn;
    cpuPkg::regAddr_t writeReg;
    cpuPkg::word_t    writeData;

    // Stimulus table, one row per cycle; rows marked random draw fresh operands on every run.
    logic          rowValid[$];
    cpuPkg::word_t rowInstr[$];
    cpuPkg::word_t rowRs[$];
    cpuPkg::word_t rowRt[$];
    logic          rowRand[$];
    logic [5:0]    aluFns[16] = '{`ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR, `NOR,
                                  `SLT, `SLTU, `SLL, `SRL, `SRA, `SLLV, `SRLV, `SRAV};

    cpuPkg::word_t hiModel;
    cpuPkg::word_t loModel;
    logic [31:0]   rngState = 32'd7;
    int            checks = 0;
    int            errors = 0;
    int            watchLimit = 0;
    int            gAlu;
    int            gImm;
    int            gMov;
    int            gHiLo;
    int            gBad;

    executeCore uut (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .resultValid (resultValid),
        .writeEn     (writeEn),
        .writeReg    (writeReg),
        .writeData   (writeData)
    );

    always #20 clk = ~clk;

    function automatic cpuPkg::word_t xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic cpuPkg::word_t rInstr(logic [5:0] op, logic [5:0] fn, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] sa);
        return {op, 5'd1, rt, rd, sa, fn};
    endfunction

    function automatic cpuPkg::word_t iInstr(logic [5:0] op, logic [4:0] rt, logic [15:0] imm);
        return {op, 5'd1, rt, imm};
    endfunction

    task automatic addRow(logic v, cpuPkg::word_t ins, cpuPkg::word_t rs, cpuPkg::word_t rt,
                          logic rnd);
        rowValid.push_back(v);
        rowInstr.push_back(ins);
        rowRs.push_back(rs);
        rowRt.push_back(rt);
        rowRand.push_back(rnd);
    endtask

    // Length of the run of bitVal starting at the MSB.
    function automatic int leadingRun(cpuPkg::word_t w, logic bitVal);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == bitVal)
            n++;
        return n;
    endfunction

    // Expected write-back of one instruction; HI/LO model changes in program order.
    function automatic void predict(cpuPkg::word_t ins, cpuPkg::word_t rs, cpuPkg::word_t rt,
                                    output logic we, output cpuPkg::regAddr_t wr,
                                    output cpuPkg::word_t wd);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [31:0] sImm;
        logic [63:0] sProd;
        logic [63:0] uProd;
        op    = ins[31:26];
        fn    = ins[5:0];
        sa    = ins[10:6];
        sImm  = {{16{ins[15]}}, ins[15:0]};
        sProd = longint'($signed(rs)) * longint'($signed(rt));
        uProd = {32'd0, rs} * {32'd0, rt};
        we    = 1'b1;
        wr    = ins[15:11];
        wd    = '0;
        if (op == `ALU)
        begin
            case (fn)
                `ADD, `ADDU: wd = rs + rt;
                `SUB, `SUBU: wd = rs - rt;
                `AND:        wd = rs & rt;
                `OR:         wd = rs | rt;
                `XOR:        wd = rs ^ rt;
                `NOR:        wd = ~(rs | rt);
                `SLL:        wd = rt << sa;
                `SRL:        wd = rt >> sa;
                `SRA:        wd = $signed(rt) >>> sa;
                `SLLV:       wd = rt << rs[4:0];
                `SRLV:       wd = rt >> rs[4:0];
                `SRAV:       wd = $signed(rt) >>> rs[4:0];
                `SLT:        wd = {31'd0, $signed(rs) < $signed(rt)};
                `SLTU:       wd = {31'd0, rs < rt};
                `MOVN, `MOVZ:
                begin
                    wd = rs;
                    we = (fn == `MOVN) ? (rt != '0) : (rt == '0);
                end
                `MFHI:       wd = hiModel;
                `MFLO:       wd = loModel;
                `MULT:       {hiModel, loModel} = sProd;
                `MULTU:      {hiModel, loModel} = uProd;
                `MTHI:       hiModel = rs;
                `MTLO:       loModel = rs;
                default:     we = 1'b0; // JR, JALR and unknown functions.
            endcase
            if (fn inside {`MULT, `MULTU, `MTHI, `MTLO})
                we = 1'b0;
        end
        else if (op == `MULL)
        begin
            case (fn)
                `MUL:    wd = sProd[31:0];
                `CLO:    wd = 32'(leadingRun(rs, 1'b1));
                `CLZ:    wd = 32'(leadingRun(rs, 1'b0));
                `MADD:   {hiModel, loModel} = {hiModel, loModel} + sProd;
                `MADDU:  {hiModel, loModel} = {hiModel, loModel} + uProd;
                `MSUB:   {hiModel, loModel} = {hiModel, loModel} - sProd;
                `MSUBU:  {hiModel, loModel} = {hiModel, loModel} - uProd;
                default: we = 1'b0;
            endcase
            if (fn inside {`MADD, `MADDU, `MSUB, `MSUBU})
                we = 1'b0;
        end
        else
        begin
            wr = ins[20:16];
            case (op)
                `ADDI, `ADDIU: wd = rs + sImm;
                `ANDI:         wd = rs & {16'd0, ins[15:0]};
                `ORI:          wd = rs | {16'd0, ins[15:0]};
                `XORI:         wd = rs ^ {16'd0, ins[15:0]};
                `SLTI:         wd = {31'd0, $signed(rs) < $signed(sImm)};
                `SLTIU:        wd = {31'd0, rs < sImm};
                `LUI:          wd = {ins[15:0], 16'd0};
                default:       we = 1'b0;
            endcase
        end
    endfunction

    task automatic checkOutputs(logic expValid, logic expWe, cpuPkg::regAddr_t expReg,
                                cpuPkg::word_t expData);
        checks++;
        assert (resultValid === expValid)
        else
        begin
            $display("Mismatch at %0t: resultValid expected %0b, got %0b", $time, expValid,
                     resultValid);
            errors++;
        end
        assert (writeEn === expWe)
        else
        begin
            $display("Mismatch at %0t: writeEn expected %0b, got %0b", $time, expWe, writeEn);
            errors++;
        end
        if (expWe)
        begin
            assert (writeReg === expReg)
            else
            begin
                $display("Mismatch at %0t: writeReg expected %0d, got %0d", $time, expReg,
                         writeReg);
                errors++;
            end
            assert (writeData === expData)
            else
            begin
                $display("Mismatch at %0t: writeData expected %h, got %h", $time, expData,
                         writeData);
                errors++;
            end
        end
    endtask

    // Drives rows first..last back to back and checks each result one cycle later.
    task automatic runGroup(string name, int first, int last);
        int               errorsBefore;
        logic             live;
        logic             prevValid;
        logic             prevWe;
        cpuPkg::regAddr_t prevReg;
        cpuPkg::word_t    prevData;
        logic             curWe;
        cpuPkg::regAddr_t curReg;
        cpuPkg::word_t    curData;
        cpuPkg::word_t    rs;
        cpuPkg::word_t    rt;
        errorsBefore = errors;
        prevValid = 1'b0;
        prevWe = 1'b0;
        prevReg = '0;
        prevData = '0;
        curReg = '0;
        curData = '0;
        for (int i = first; i <= last + 1; i++)
        begin
            live = 1'b0;
            if (i <= last)
                live = rowValid[i];
            @(posedge clk);
            if (live)
            begin
                rs = rowRand[i] ? xorshift() : rowRs[i];
                rt = rowRand[i] ? xorshift() : rowRt[i];
                predict(rowInstr[i], rs, rt, curWe, curReg, curData);
                instrValid <= 1'b1;
                instr      <= rowInstr[i];
                rsData     <= rs;
                rtData     <= rt;
            end
            else
            begin
                curWe = 1'b0;
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (i > first)
                checkOutputs(prevValid, prevWe, prevReg, prevData);
            prevValid = live;
            prevWe = curWe;
            prevReg = curReg;
            prevData = curData;
        end
        $display("Test %s finished: %0d errors", name, errors - errorsBefore);
    endtask

    initial
    begin
        wait (watchLimit > 0);
        #(watchLimit);
        $display("Timeout: the run did not finish within %0d ns", watchLimit);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rsData     = '0;
        rtData     = '0;
        hiModel    = '0;
        loModel    = '0;

        addRow(1'b0, '0, '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `ADDU, 5'd2, 5'd4, 5'd0), '0, '0, 1'b1);
        addRow(1'b0, '0, '0, '0, 1'b0);
        addRow(1'b0, '0, '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `OR, 5'd2, 5'd5, 5'd0), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `SUBU, 5'd2, 5'd6, 5'd0), '0, '0, 1'b1);
        addRow(1'b0, '0, '0, '0, 1'b0);

        gAlu = rowValid.size();
        foreach (aluFns[k])
            addRow(1'b1, rInstr(`ALU, aluFns[k], 5'd2, 5'(k + 3), 5'(k * 3)), '0, '0, 1'b1);

        gImm = rowValid.size();
        addRow(1'b1, iInstr(`ADDI, 5'd7, 16'h8001), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`ADDIU, 5'd8, 16'hFFF0), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`ANDI, 5'd9, 16'hF0F0), 32'hFFFF_FFFF, '0, 1'b0);
        addRow(1'b1, iInstr(`ORI, 5'd10, 16'h8000), 32'h1234_0000, '0, 1'b0);
        addRow(1'b1, iInstr(`XORI, 5'd11, 16'hFFFF), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`SLTI, 5'd12, 16'hFFFE), 32'd5, '0, 1'b0);
        addRow(1'b1, iInstr(`SLTIU, 5'd13, 16'hFFFF), 32'h0001_0000, '0, 1'b0);
        addRow(1'b1, iInstr(`SLTIU, 5'd14, 16'h0004), 32'd5, '0, 1'b0);
        addRow(1'b1, iInstr(`LUI, 5'd15, 16'hBEEF), '0, '0, 1'b1);

        gMov = rowValid.size();
        addRow(1'b1, rInstr(`ALU, `MOVN, 5'd3, 5'd16, 5'd0), 32'h0000_CAFE, 32'd0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MOVN, 5'd3, 5'd17, 5'd0), 32'h0000_CAFE, 32'd5, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MOVZ, 5'd3, 5'd18, 5'd0), 32'h0000_BEEF, 32'd0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MOVZ, 5'd3, 5'd19, 5'd0), 32'h0000_BEEF, 32'd9, 1'b0);

        // Each HI/LO update is read back by the very next instruction.
        gHiLo = rowValid.size();
        addRow(1'b1, rInstr(`ALU, `MULT, 5'd3, 5'd0, 5'd0), 32'hFFFF_FFFD, 32'd7, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFLO, 5'd0, 5'd20, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFHI, 5'd0, 5'd21, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `MADD, 5'd3, 5'd0, 5'd0), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `MFHI, 5'd0, 5'd22, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFLO, 5'd0, 5'd23, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `MSUBU, 5'd3, 5'd0, 5'd0), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `MFLO, 5'd0, 5'd24, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFHI, 5'd0, 5'd25, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MTHI, 5'd0, 5'd0, 5'd0), 32'h1357_9BDF, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFHI, 5'd0, 5'd26, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MTLO, 5'd0, 5'd0, 5'd0), 32'h2468_ACE0, '0, 1'b0);
        addRow(1'b1, rInstr(`ALU, `MFLO, 5'd0, 5'd27, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `MUL, 5'd3, 5'd28, 5'd0), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `MFLO, 5'd0, 5'd29, 5'd0), '0, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `CLO, 5'd0, 5'd30, 5'd0), 32'hFFFF_FFFF, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `CLO, 5'd0, 5'd30, 5'd0), 32'hF000_0000, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `CLZ, 5'd0, 5'd31, 5'd0), 32'h0000_0000, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `CLZ, 5'd0, 5'd31, 5'd0), 32'h0001_0000, '0, 1'b0);
        addRow(1'b1, rInstr(`MULL, `CLO, 5'd0, 5'd30, 5'd0), '0, '0, 1'b1);

        gBad = rowValid.size();
        addRow(1'b1, iInstr(`BEQ, 5'd3, 16'h0010), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`LW, 5'd4, 16'h0020), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`SW, 5'd5, 16'h0030), '0, '0, 1'b1);
        addRow(1'b1, iInstr(`J, 5'd6, 16'h0040), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `JR, 5'd0, 5'd0, 5'd0), '0, '0, 1'b1);
        addRow(1'b1, rInstr(`ALU, `JALR, 5'd0, 5'd31, 5'd0), '0, '0, 1'b1);

        watchLimit = (rowValid.size() * 2 + 40) * 40; // The ALU rows run twice.

        repeat (2) @(posedge clk);
        @(negedge clk);
        checkOutputs(1'b0, 1'b0, '0, '0);
        $display("Test reset finished: %0d errors", errors);
        @(posedge clk);
        arstN <= 1'b1;

        runGroup("idle and strobes", 0, gAlu - 1);
        runGroup("register ALU", gAlu, gImm - 1);
        runGroup("register ALU with new operands", gAlu, gImm - 1);
        runGroup("immediate forms", gImm, gMov - 1);
        runGroup("MOVN and MOVZ", gMov, gHiLo - 1);
        runGroup("HI/LO and counts", gHiLo, gBad - 1);
        runGroup("unsupported opcodes", gBad, rowValid.size() - 1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
